// File: logic/ntt_pkg.sv
`default_nettype none

package ntt_pkg;

    // ------------------------------------------------------------
    // datapath sizes
    // ------------------------------------------------------------
    localparam int unsigned WORD_W     = 16;
    localparam int unsigned MODULUS    = 12289;
    localparam int unsigned N_POINTS   = 16;
    localparam int unsigned N_STAGES   = 4;
    // twiddle k (1..15) sits at index k-1
    localparam int unsigned N_TWIDDLES = 15;

    // pipeline depth
    localparam int unsigned BU_LATENCY   = 2;
    localparam int unsigned CORE_LATENCY = N_STAGES * BU_LATENCY;

    typedef logic [WORD_W-1:0]                 word_t;
    typedef word_t [N_POINTS-1:0]              vector_t;
    typedef word_t [N_TWIDDLES-1:0]            twiddle_set_t;

    // ------------------------------------------------------------
    // butterfly routing for one radix-2 stage
    // ------------------------------------------------------------
    // lower position of butterfly bu in the given stage
    function automatic int unsigned bu_lo_pos(int unsigned stage, int unsigned bu);
        int unsigned half;
        half = (N_POINTS / 2) >> stage;
        return (bu / half) * 2 * half + bu % half;
    endfunction

    // partner sits one half-span above
    function automatic int unsigned bu_hi_pos(int unsigned stage, int unsigned bu);
        int unsigned half;
        half = (N_POINTS / 2) >> stage;
        return bu_lo_pos(stage, bu) + half;
    endfunction

    // block k of stage s takes twiddle 2^s + k
    function automatic int unsigned bu_twiddle_idx(int unsigned stage, int unsigned bu);
        int unsigned half;
        half = (N_POINTS / 2) >> stage;
        return (1 << stage) + bu / half - 1;
    endfunction

endpackage

`default_nettype wire

// File: logic/stage_link_if.sv
`default_nettype none

// one vector in flight between two stages
interface stage_link_if import ntt_pkg::*; ();

    logic         valid;
    vector_t      data;
    twiddle_set_t twiddles;

    // driving stage
    modport src (
        output valid,
        output data,
        output twiddles
    );

    // receiving stage
    modport dst (
        input valid,
        input data,
        input twiddles
    );

endinterface

`default_nettype wire

// File: logic/ct_butterfly.sv
`default_nettype none

module ct_butterfly import ntt_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t a_in,
    input  word_t b_in,
    input  word_t twiddle,
    output word_t a_out,
    output word_t b_out
);

    logic [2*WORD_W-1:0] prod;
    word_t               prod_red;
    word_t               p_q;
    word_t               a_q;
    logic [WORD_W:0]     sum;
    logic [WORD_W:0]     diff;

    // ------------------------------------------------------------
    // cycle 1: twiddle * b mod q
    // ------------------------------------------------------------
    always_comb begin
        prod     = twiddle * b_in;
        prod_red = word_t'(prod % MODULUS);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p_q <= '0;
            a_q <= '0;
        end else begin
            p_q <= prod_red;
            // a rides along to meet the product
            a_q <= a_in;
        end
    end

    // ------------------------------------------------------------
    // cycle 2: a + p and a - p, both mod q
    // ------------------------------------------------------------
    always_comb begin
        sum  = {1'b0, a_q} + {1'b0, p_q};
        diff = {1'b0, a_q} - {1'b0, p_q};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= (sum >= MODULUS) ? word_t'(sum - MODULUS) : word_t'(sum);
            // borrow out of the top bit means a < p
            b_out <= diff[WORD_W] ? word_t'(diff + MODULUS) : word_t'(diff);
        end
    end

    // results stay reduced two cycles after reduced operands
    a_b_out_reduced: assert property (
        @(posedge clk) disable iff (rst)
        (a_out < MODULUS) && (b_out < MODULUS)
    );

endmodule

`default_nettype wire

// File: logic/radix2_stage.sv
`default_nettype none

module radix2_stage import ntt_pkg::*; #(
    parameter int unsigned STAGE = 0
) (
    input logic             clk,
    input logic             rst,
    stage_link_if.dst       up,
    stage_link_if.src       down
);

    word_t        a_res [N_POINTS/2];
    word_t        b_res [N_POINTS/2];
    vector_t      data_out;
    twiddle_set_t twid_pipe [BU_LATENCY];
    logic [BU_LATENCY-1:0] valid_pipe;
    logic         up_in_range;

    // ------------------------------------------------------------
    // eight butterflies, pairs chosen by stage index
    // ------------------------------------------------------------
    for (genvar i = 0; i < N_POINTS / 2; i++) begin : g_bu
        ct_butterfly u_bu (
            .clk     (clk),
            .rst     (rst),
            .a_in    (up.data[bu_lo_pos(STAGE, i)]),
            .b_in    (up.data[bu_hi_pos(STAGE, i)]),
            .twiddle (up.twiddles[bu_twiddle_idx(STAGE, i)]),
            .a_out   (a_res[i]),
            .b_out   (b_res[i])
        );
    end

    // in-place write back
    always_comb begin
        data_out = '0;
        for (int i = 0; i < N_POINTS / 2; i++) begin
            data_out[bu_lo_pos(STAGE, i)] = a_res[i];
            data_out[bu_hi_pos(STAGE, i)] = b_res[i];
        end
    end

    // ------------------------------------------------------------
    // twiddle and valid delay, matched to butterfly latency
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        twid_pipe[0] <= up.twiddles;
        for (int k = 1; k < BU_LATENCY; k++) begin
            twid_pipe[k] <= twid_pipe[k-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= up.valid;
            for (int k = 1; k < BU_LATENCY; k++) begin
                valid_pipe[k] <= valid_pipe[k-1];
            end
        end
    end

    assign down.valid    = valid_pipe[BU_LATENCY-1];
    assign down.data     = data_out;
    assign down.twiddles = twid_pipe[BU_LATENCY-1];

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    always_comb begin
        up_in_range = 1'b1;
        for (int i = 0; i < N_POINTS; i++) begin
            if (up.data[i] >= MODULUS) begin
                up_in_range = 1'b0;
            end
        end
    end

    // upstream stage or core input must hand over reduced residues
    up_data_reduced: assert property (
        @(posedge clk) disable iff (rst)
        up.valid |-> up_in_range
    );

endmodule

`default_nettype wire

// File: logic/radix16_ntt_core.sv
`default_nettype none

module radix16_ntt_core import ntt_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  vector_t      x,
    input  twiddle_set_t twiddle,
    output logic         out_valid,
    output vector_t      y
);

    // link s feeds stage s, the last one feeds the outputs
    stage_link_if link [N_STAGES+1] ();

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------
    assign link[0].valid    = in_valid;
    assign link[0].data     = x;
    assign link[0].twiddles = twiddle;

    // ------------------------------------------------------------
    // four radix-2 stages, half-span 8, 4, 2, 1
    // ------------------------------------------------------------
    for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
        radix2_stage #(
            .STAGE (s)
        ) u_stage (
            .clk  (clk),
            .rst  (rst),
            .up   (link[s]),
            .down (link[s+1])
        );
    end

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------
    assign out_valid = link[N_STAGES].valid;
    assign y         = link[N_STAGES].data;

    // valid walks through all stages with fixed latency
    // waits until the pipe has refilled after reset
    property p_valid_latency;
        @(posedge clk) disable iff (rst)
        !$past(rst, CORE_LATENCY) |-> (out_valid == $past(in_valid, CORE_LATENCY));
    endproperty

    valid_latency: assert property (p_valid_latency);

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the active edge
        @(negedge clk);
        rst = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: verification/tb_radix16_ntt.sv
`default_nettype none

module tb_radix16_ntt import ntt_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic         clk;
    logic         rst;
    logic         in_valid;
    vector_t      x;
    twiddle_set_t twiddle;
    logic         out_valid;
    vector_t      y;

    // expected results and the cycle each input was sampled in
    vector_t      exp_q [$];
    int           exp_cyc_q [$];
    vector_t      head_vec = '0;
    int           head_cycle = 0;
    logic         q_empty = 1'b1;
    int           cycle_cnt = 0;
    int           mismatch_pos;
    logic         first_sent;
    int           value_errors = 0;
    int           timeout_errors = 0;
    logic [15:0]  lfsr_state = 16'd60692;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    radix16_ntt_core radix16_ntt_core_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .x         (x),
        .twiddle   (twiddle),
        .out_valid (out_valid),
        .y         (y)
    );

    // ------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic int unsigned take_bits(int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic word_t random_residue();
        int unsigned r;
        r = take_bits(14);
        if (r >= MODULUS) begin
            r = r - MODULUS;
        end
        return word_t'(r);
    endfunction

    // four in-place radix-2 passes, half-span 8 down to 1
    function automatic vector_t ntt_reference(vector_t v, twiddle_set_t t);
        vector_t         r;
        int              h;
        int              lo;
        int              hi;
        longint unsigned a;
        longint unsigned b;
        longint unsigned w;
        longint unsigned p;
        r = v;
        for (int s = 0; s < N_STAGES; s++) begin
            h = (N_POINTS / 2) >> s;
            for (int k = 0; k < N_POINTS / (2 * h); k++) begin
                for (int j = 0; j < h; j++) begin
                    lo = k * 2 * h + j;
                    hi = lo + h;
                    a = r[lo];
                    b = r[hi];
                    w = t[(1 << s) + k - 1];
                    p = (w * b) % MODULUS;
                    r[lo] = word_t'((a + p) % MODULUS);
                    r[hi] = (a >= p) ? word_t'(a - p) : word_t'(a + MODULUS - p);
                end
            end
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // expected-result queue
    // ------------------------------------------------------------
    task automatic refresh_head();
        if (exp_q.size() > 0) begin
            head_vec   <= exp_q[0];
            head_cycle <= exp_cyc_q[0];
            q_empty    <= 1'b0;
        end else begin
            q_empty    <= 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            void'(exp_cyc_q.pop_front());
            refresh_head();
        end
    end

    always_comb begin
        mismatch_pos = -1;
        for (int i = N_POINTS - 1; i >= 0; i--) begin
            if (y[i] !== head_vec[i]) begin
                mismatch_pos = i;
            end
        end
    end

    task automatic report_mismatch(int pos, vector_t got, vector_t want);
        $display("FAILED at %0t: y[%0d] = %0d, expected %0d",
                 $time, pos, got[pos], want[pos]);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    idle_before_input: assert property (
        @(posedge clk) (cycle_cnt > 0 && !first_sent) |-> (!out_valid && y == '0)
    ) else begin
        value_errors++;
        $display("FAILED at %0t: output not idle before the first input", $time);
    end

    no_unexpected_output: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> !q_empty
    ) else begin
        value_errors++;
        $display("FAILED at %0t: out_valid high with no vector in flight", $time);
    end

    output_matches_reference: assert property (
        @(posedge clk) disable iff (rst) (out_valid && !q_empty) |-> (mismatch_pos < 0)
    ) else begin
        value_errors++;
        report_mismatch($sampled(mismatch_pos), $sampled(y), $sampled(head_vec));
    end

    output_latency: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !q_empty) |-> (cycle_cnt == head_cycle + int'(CORE_LATENCY))
    ) else begin
        value_errors++;
        $display("FAILED at %0t: output in cycle %0d, expected cycle %0d",
                 $time, $sampled(cycle_cnt), $sampled(head_cycle) + int'(CORE_LATENCY));
    end

    valid_pattern_delay: assert property (
        @(posedge clk) disable iff (rst)
        (cycle_cnt >= int'(CORE_LATENCY)) |-> (out_valid == $past(in_valid, CORE_LATENCY))
    ) else begin
        value_errors++;
        $display("FAILED at %0t: out_valid does not follow in_valid", $time);
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic send_vector(input vector_t v, input twiddle_set_t t);
        @(negedge clk);
        in_valid   = 1'b1;
        x          = v;
        twiddle    = t;
        first_sent = 1'b1;
        exp_q.push_back(ntt_reference(v, t));
        exp_cyc_q.push_back(cycle_cnt);
        refresh_head();
    endtask

    task automatic hold_idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        vector_t      v;
        twiddle_set_t t;
        for (int i = 0; i < N_POINTS; i++) begin
            v[i] = random_residue();
        end
        for (int i = 0; i < N_TWIDDLES; i++) begin
            t[i] = random_residue();
        end
        send_vector(v, t);
    endtask

    task automatic send_edge_vectors();
        vector_t      v;
        twiddle_set_t t;
        // largest residues, every sum wraps
        for (int i = 0; i < N_POINTS; i++) begin
            v[i] = word_t'(MODULUS - 1);
        end
        for (int i = 0; i < N_TWIDDLES; i++) begin
            t[i] = word_t'(MODULUS - 1);
        end
        send_vector(v, t);
        send_vector('0, '0);
        // unit twiddles, plain add/sub network
        for (int i = 0; i < N_POINTS; i++) begin
            v[i] = random_residue();
        end
        for (int i = 0; i < N_TWIDDLES; i++) begin
            t[i] = word_t'(1);
        end
        send_vector(v, t);
    endtask

    task automatic wait_for_reset_release(int limit);
        int waited;
        waited = 0;
        while (rst && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (rst) begin
            timeout_errors++;
            $display("timeout: reset still asserted after %0d cycles", limit);
        end
    endtask

    task automatic wait_for_drain(int limit, string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d results of %s missing after %0d cycles",
                     exp_q.size(), what, limit);
        end
    endtask

    initial begin
        in_valid   = 1'b0;
        x          = '0;
        twiddle    = '0;
        first_sent = 1'b0;

        wait_for_reset_release(40);
        repeat (12) hold_idle();

        // one vector alone
        send_random();
        hold_idle();
        wait_for_drain(CORE_LATENCY + 4, "the single vector");

        // back-to-back burst
        repeat (20) send_random();
        hold_idle();
        wait_for_drain(CORE_LATENCY + 8, "the burst");

        // gaps in the stream
        for (int i = 0; i < 48; i++) begin
            if (take_bits(1) == 1) begin
                send_random();
            end else begin
                hold_idle();
            end
        end
        hold_idle();
        wait_for_drain(CORE_LATENCY + 8, "the gapped stream");

        send_edge_vectors();
        hold_idle();
        wait_for_drain(CORE_LATENCY + 8, "the edge vectors");

        repeat (4) hold_idle();

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/ntt_pkg.sv
logic/stage_link_if.sv
logic/ct_butterfly.sv
logic/radix2_stage.sv
logic/radix16_ntt_core.sv
verification/tb_clock_gen.sv
verification/tb_radix16_ntt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the radix-16 NTT testbench with Verilator.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_radix16_ntt \
    -Mdir "$BUILD_DIR" \
    -o sim_tb_radix16_ntt

"./$BUILD_DIR/sim_tb_radix16_ntt" | tee "$LOG_FILE"

if grep -qx "TESTBENCH PASSED" "$LOG_FILE"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi
